// File: compile.f
source/game_pkg.sv
source/delay.sv
source/vga_timing.sv
source/background_draw.sv
source/round_control.sv
source/gloves_control.sv
source/penalty_top.sv
testbench/penalty_tb.sv

// File: testbench/penalty_tb.sv
// Penalty keeper round testbench
`timescale 1ns/1ns

module penalty_tb;

    localparam int H_TOTAL      = 40;
    localparam int H_ACTIVE     = 32;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_END   = 37;
    localparam int V_TOTAL      = 30;
    localparam int V_ACTIVE     = 24;
    localparam int V_SYNC_START = 25;
    localparam int V_SYNC_END   = 27;
    localparam int HORIZON      = 10;
    localparam int CROSS        = 4;
    // Raster spot that puts line 12, columns 10 to 14, at the end of the countdown.
    localparam int AIM_V = 11;
    localparam int AIM_H = 17;

    logic                       clk;
    logic                       rst;
    logic [game_pkg::POS_W-1:0] xpos, ypos, shot_xpos, shot_ypos;
    logic                       shot_valid, shot_ready;
    logic [game_pkg::CNT_W-1:0] hcount, vcount;
    logic                       hsync, vsync, hblnk, vblnk;
    logic [game_pkg::RGB_W-1:0] rgb;
    logic                       round_done, is_scored;
    logic [7:0]                 goals, saves;

    int     errors;
    int     tests_failed;
    int     exp_goals;
    int     exp_saves;
    integer seed;

    penalty_top #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END),
        .HORIZON(HORIZON), .SECOND_TICKS(15), .RESULT_TICKS(7), .CROSS_WIDTH(CROSS)
    ) dut0 (
        .clk(clk), .rst(rst), .xpos(xpos), .ypos(ypos),
        .shot_valid(shot_valid), .shot_xpos(shot_xpos), .shot_ypos(shot_ypos),
        .shot_ready(shot_ready), .hcount(hcount), .vcount(vcount),
        .hsync(hsync), .vsync(vsync), .hblnk(hblnk), .vblnk(vblnk), .rgb(rgb),
        .round_done(round_done), .is_scored(is_scored), .goals(goals), .saves(saves)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //******************************************************************
    // Reference rules and helpers
    //******************************************************************
    function automatic logic [game_pkg::RGB_W-1:0] bg_colour(input int v, input logic hb,
                                                             input logic vb);
        if (hb || vb) return game_pkg::COLOR_BLANK;
        if (v < HORIZON) return game_pkg::COLOR_SKY;
        return game_pkg::COLOR_GRASS;
    endfunction

    function automatic bit in_square(input int x, input int y, input int sx, input int sy);
        return x >= sx && x <= sx + CROSS && y >= sy && y <= sy + CROSS; // Ends included.
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string name, input int exp_val, input int act_val);
        $display("mismatch %s: expected %0h, actual %0h", name, exp_val, act_val);
        errors++;
    endtask

    task automatic report_problem(input string name, input string what);
        $display("%s: %s", name, what);
        errors++;
    endtask

    task automatic close_test(input string name, input int mark);
        if (errors == mark) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d error lines", name, errors - mark);
            tests_failed++;
        end
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (!shot_ready && n < 100) begin
            next_cycle();
            n++;
        end
        if (!shot_ready) report_problem(name, "timeout waiting for shot_ready");
    endtask

    task automatic wait_raster(input string name, input int v, input int h);
        int n;
        n = 0;
        while (!(vcount == v && hcount == h) && n < H_TOTAL * V_TOTAL + 10) begin
            next_cycle();
            n++;
        end
        if (!(vcount == v && hcount == h)) report_problem(name, "raster never reached");
    endtask

    // Holds the shot until the transfer edge, then drops valid.
    task automatic send_shot(input string name, input int sx, input int sy);
        int n;
        shot_xpos  = sx;
        shot_ypos  = sy;
        shot_valid = 1'b1;
        n = 0;
        while (!shot_ready && n < 100) begin
            next_cycle();
            n++;
        end
        if (!shot_ready) report_problem(name, "shot was never accepted");
        next_cycle();
        shot_valid = 1'b0;
    endtask

    // Watches every output pixel until round_done, then checks result and counts.
    task automatic wait_round(input string name, input int sx, input int sy,
                              input bit exp_scored, input bit check_colour);
        int                         n;
        bit                         done;
        bit                         seen_aim;
        bit                         seen_res;
        logic [game_pkg::RGB_W-1:0] bg;
        logic [game_pkg::RGB_W-1:0] res_col;
        res_col  = exp_scored ? game_pkg::COLOR_GOAL : game_pkg::COLOR_SAVE;
        done     = 1'b0;
        seen_aim = 1'b0;
        seen_res = 1'b0;
        n = 0;
        while (!done && n < 300) begin
            bg = bg_colour(vcount, hblnk, vblnk);
            if (shot_ready) report_problem(name, "shot_ready high while a round runs");
            if (!in_square(hcount, vcount, sx, sy)) begin
                if (rgb != bg) report_mismatch(name, bg, rgb);
            end else if (rgb == game_pkg::COLOR_AIM) begin
                seen_aim = 1'b1;
            end else if (rgb == res_col) begin
                if (seen_aim) seen_res = 1'b1;
            end else if (rgb != bg) begin
                report_mismatch(name, bg, rgb);
            end
            if (round_done) begin
                done = 1'b1;
                if (is_scored != exp_scored) report_mismatch(name, exp_scored, is_scored);
            end else begin
                next_cycle();
                n++;
            end
        end
        if (!done) begin
            report_problem(name, "timeout waiting for round_done");
            return;
        end
        if (exp_scored) exp_goals++;
        else exp_saves++;
        next_cycle(); // Counts update one edge after round_done.
        if (goals != exp_goals) report_mismatch(name, exp_goals, goals);
        if (saves != exp_saves) report_mismatch(name, exp_saves, saves);
        if (check_colour && !seen_aim) report_problem(name, "aim colour never shown");
        if (check_colour && !seen_res) report_problem(name, "result colour never shown");
        wait_ready(name);
    endtask

    task automatic run_round(input string name, input int sx, input int sy,
                             input int gx, input int gy, input bit aimed);
        bit scored;
        xpos   = gx;
        ypos   = gy;
        scored = !in_square(gx, gy, sx, sy);
        wait_ready(name);
        if (aimed) wait_raster(name, AIM_V, AIM_H);
        send_shot(name, sx, sy);
        wait_round(name, sx, sy, scored, aimed);
    endtask

    //******************************************************************
    // Tests
    //******************************************************************
    task automatic test_reset();
        int mark;
        mark = errors;
        rst  = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        if (shot_ready !== 1'b1) report_mismatch("reset_state", 1, shot_ready);
        if (round_done !== 1'b0) report_mismatch("reset_state", 0, round_done);
        if (is_scored !== 1'b0) report_mismatch("reset_state", 0, is_scored);
        if (goals !== 8'd0) report_mismatch("reset_state", 0, goals);
        if (saves !== 8'd0) report_mismatch("reset_state", 0, saves);
        if ({hsync, vsync, hblnk, vblnk} !== 4'b0)
            report_mismatch("reset_state", 0, {hsync, vsync, hblnk, vblnk});
        if (rgb !== '0) report_mismatch("reset_state", 0, rgb);
        rst = 1'b0;
        close_test("reset_state", mark);
    endtask

    task automatic test_background();
        int                         mark;
        int                         prev;
        int                         cur;
        logic [game_pkg::RGB_W-1:0] bg;
        mark = errors;
        prev = -1;
        next_cycle(); // Pipeline fill after reset.
        next_cycle();
        for (int n = 0; n < H_TOTAL * V_TOTAL; n++) begin
            bg  = bg_colour(vcount, hblnk, vblnk);
            cur = vcount * H_TOTAL + hcount;
            if (rgb != bg) report_mismatch("background", bg, rgb);
            if (hblnk != (hcount >= H_ACTIVE)) report_mismatch("background", !hblnk, hblnk);
            if (vblnk != (vcount >= V_ACTIVE)) report_mismatch("background", !vblnk, vblnk);
            if (hsync != (hcount >= H_SYNC_START && hcount < H_SYNC_END))
                report_mismatch("background", !hsync, hsync);
            if (vsync != (vcount >= V_SYNC_START && vcount < V_SYNC_END))
                report_mismatch("background", !vsync, vsync);
            if (prev >= 0 && cur != (prev + 1) % (H_TOTAL * V_TOTAL))
                report_mismatch("background", (prev + 1) % (H_TOTAL * V_TOTAL), cur);
            prev = cur;
            next_cycle();
        end
        close_test("background", mark);
    endtask

    task automatic test_save_round();
        int mark;
        mark = errors;
        run_round("save_round", 10, 10, 12, 12, 1'b1);
        close_test("save_round", mark);
    endtask

    task automatic test_goal_round();
        int mark;
        mark = errors;
        run_round("goal_round", 10, 10, 20, 12, 1'b1);
        close_test("goal_round", mark);
    endtask

    task automatic test_backpressure();
        int mark;
        mark = errors;
        xpos = 12;
        ypos = 12;
        wait_ready("backpressure");
        send_shot("backpressure", 10, 10);
        // Second shot stays offered for the whole first round.
        shot_xpos  = 20;
        shot_ypos  = 5;
        shot_valid = 1'b1;
        wait_round("backpressure", 10, 10, 1'b0, 1'b0);
        next_cycle(); // Transfer of the second shot.
        shot_valid = 1'b0;
        if (shot_ready) report_problem("backpressure", "second shot not taken on ready");
        wait_round("backpressure", 20, 5, !in_square(12, 12, 20, 5), 1'b0);
        close_test("backpressure", mark);
    endtask

    task automatic test_random_rounds();
        int mark;
        int sx;
        int sy;
        int gx;
        int gy;
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            sx = 2 + {$random(seed)} % 24;
            sy = 2 + {$random(seed)} % 16;
            gx = sx - 2 + {$random(seed)} % 8; // Near the square, so both outcomes occur.
            gy = sy - 2 + {$random(seed)} % 8;
            run_round("random_rounds", sx, sy, gx, gy, 1'b0);
        end
        close_test("random_rounds", mark);
    endtask

    initial begin
        rst          = 1'b1;
        shot_valid   = 1'b0;
        shot_xpos    = '0;
        shot_ypos    = '0;
        xpos         = '0;
        ypos         = '0;
        errors       = 0;
        tests_failed = 0;
        exp_goals    = 0;
        exp_saves    = 0;
        seed         = 91360;
        test_reset();
        test_background();
        test_save_round();
        test_goal_round();
        test_backpressure();
        test_random_rounds();
        $display("tests 6, failed %0d, error lines %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: source/penalty_top.sv
// Penalty keeper round top level
`timescale 1ns/1ns

module penalty_top #(
    parameter int H_ACTIVE     = 1024,
    parameter int H_TOTAL      = 1344,
    parameter int H_SYNC_START = 1048,
    parameter int H_SYNC_END   = 1184,
    parameter int V_ACTIVE     = 768,
    parameter int V_TOTAL      = 806,
    parameter int V_SYNC_START = 771,
    parameter int V_SYNC_END   = 777,
    parameter int HORIZON      = 300,
    parameter int SECOND_TICKS = 65_000_000,
    parameter int RESULT_TICKS = 13_000_000,
    parameter int CROSS_WIDTH  = 100
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::POS_W-1:0] xpos,
    input  logic [game_pkg::POS_W-1:0] ypos,
    input  logic                       shot_valid,
    input  logic [game_pkg::POS_W-1:0] shot_xpos,
    input  logic [game_pkg::POS_W-1:0] shot_ypos,
    output logic                       shot_ready,
    output logic [game_pkg::CNT_W-1:0] hcount,
    output logic [game_pkg::CNT_W-1:0] vcount,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       hblnk,
    output logic                       vblnk,
    output logic [game_pkg::RGB_W-1:0] rgb,
    output logic                       round_done,
    output logic                       is_scored,
    output logic [7:0]                 goals,
    output logic [7:0]                 saves
);

    // Timing stage.
    logic [game_pkg::CNT_W-1:0] tim_hcount, tim_vcount;
    logic                       tim_hsync, tim_vsync, tim_hblnk, tim_vblnk;
    // Background stage.
    logic [game_pkg::CNT_W-1:0] bg_hcount, bg_vcount;
    logic                       bg_hsync, bg_vsync, bg_hblnk, bg_vblnk;
    logic [game_pkg::RGB_W-1:0] bg_rgb;
    // Round state.
    logic [game_pkg::POS_W-1:0] shot_xpos_q, shot_ypos_q;
    game_pkg::g_state           game_state;

    vga_timing #(
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .H_SYNC_START(H_SYNC_START),
        .H_SYNC_END  (H_SYNC_END),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .V_SYNC_START(V_SYNC_START),
        .V_SYNC_END  (V_SYNC_END)
    ) u_vga_timing (
        .clk   (clk),
        .rst   (rst),
        .hcount(tim_hcount),
        .vcount(tim_vcount),
        .hsync (tim_hsync),
        .vsync (tim_vsync),
        .hblnk (tim_hblnk),
        .vblnk (tim_vblnk)
    );

    background_draw #(
        .HORIZON(HORIZON)
    ) u_background_draw (
        .clk       (clk),
        .rst       (rst),
        .hcount_in (tim_hcount),
        .vcount_in (tim_vcount),
        .hsync_in  (tim_hsync),
        .vsync_in  (tim_vsync),
        .hblnk_in  (tim_hblnk),
        .vblnk_in  (tim_vblnk),
        .hcount_out(bg_hcount),
        .vcount_out(bg_vcount),
        .hsync_out (bg_hsync),
        .vsync_out (bg_vsync),
        .hblnk_out (bg_hblnk),
        .vblnk_out (bg_vblnk),
        .rgb_out   (bg_rgb)
    );

    round_control u_round_control (
        .clk        (clk),
        .rst        (rst),
        .shot_valid (shot_valid),
        .shot_ready (shot_ready),
        .shot_xpos  (shot_xpos),
        .shot_ypos  (shot_ypos),
        .shot_xpos_q(shot_xpos_q),
        .shot_ypos_q(shot_ypos_q),
        .game_state (game_state),
        .round_done (round_done),
        .is_scored  (is_scored),
        .goals      (goals),
        .saves      (saves)
    );

    gloves_control #(
        .SECOND_TICKS(SECOND_TICKS),
        .RESULT_TICKS(RESULT_TICKS),
        .CROSS_WIDTH (CROSS_WIDTH)
    ) u_gloves_control (
        .clk       (clk),
        .rst       (rst),
        .xpos      (xpos),
        .ypos      (ypos),
        .game_state(game_state),
        .shot_xpos (shot_xpos_q),
        .shot_ypos (shot_ypos_q),
        .hcount_in (bg_hcount),
        .vcount_in (bg_vcount),
        .hsync_in  (bg_hsync),
        .vsync_in  (bg_vsync),
        .hblnk_in  (bg_hblnk),
        .vblnk_in  (bg_vblnk),
        .rgb_in    (bg_rgb),
        .hcount_out(hcount),
        .vcount_out(vcount),
        .hsync_out (hsync),
        .vsync_out (vsync),
        .hblnk_out (hblnk),
        .vblnk_out (vblnk),
        .rgb_out   (rgb),
        .is_scored (is_scored),
        .round_done(round_done)
    );

endmodule

// File: source/gloves_control.sv
// Goalkeeper round controller
`timescale 1ns/1ns

module gloves_control #(
    parameter int SECOND_TICKS = 65_000_000,
    parameter int RESULT_TICKS = 13_000_000,
    parameter int CROSS_WIDTH  = 100
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::POS_W-1:0] xpos,
    input  logic [game_pkg::POS_W-1:0] ypos,
    input  game_pkg::g_state           game_state,
    input  logic [game_pkg::POS_W-1:0] shot_xpos,
    input  logic [game_pkg::POS_W-1:0] shot_ypos,
    input  logic [game_pkg::CNT_W-1:0] hcount_in,
    input  logic [game_pkg::CNT_W-1:0] vcount_in,
    input  logic                       hsync_in,
    input  logic                       vsync_in,
    input  logic                       hblnk_in,
    input  logic                       vblnk_in,
    input  logic [game_pkg::RGB_W-1:0] rgb_in,
    output logic [game_pkg::CNT_W-1:0] hcount_out,
    output logic [game_pkg::CNT_W-1:0] vcount_out,
    output logic                       hsync_out,
    output logic                       vsync_out,
    output logic                       hblnk_out,
    output logic                       vblnk_out,
    output logic [game_pkg::RGB_W-1:0] rgb_out,
    output logic                       is_scored,
    output logic                       round_done
);

    localparam int PW       = game_pkg::POS_W;
    localparam int TICK_MAX = (SECOND_TICKS > RESULT_TICKS) ? SECOND_TICKS : RESULT_TICKS;
    localparam int TICK_W   = $clog2(TICK_MAX + 1);
    localparam logic [TICK_W-1:0] SEC_END = TICK_W'(SECOND_TICKS);
    localparam logic [TICK_W-1:0] RES_END = TICK_W'(RESULT_TICKS);
    localparam logic [PW:0]       CW      = (PW + 1)'(CROSS_WIDTH);

    typedef enum logic [2:0] {
        IDLE,
        ENGAGE,
        COUNTDOWN,
        RESULT,
        GOAL,
        SAVE,
        TERMINATE
    } glove_state;

    glove_state                 state, state_nxt;
    logic [TICK_W-1:0]          counter, counter_nxt;
    logic [game_pkg::RGB_W-1:0] rgb_nxt;
    logic                       is_scored_nxt;
    logic                       round_done_nxt;
    logic                       pixel_in_sq;
    logic                       glove_in_sq;

    // Both ends of the square are inside; one extra bit keeps the sum exact.
    function automatic logic in_square(input logic [PW-1:0] x, input logic [PW-1:0] y);
        return ({1'b0, x} >= {1'b0, shot_xpos}) && ({1'b0, x} <= {1'b0, shot_xpos} + CW) &&
               ({1'b0, y} >= {1'b0, shot_ypos}) && ({1'b0, y} <= {1'b0, shot_ypos} + CW);
    endfunction

    assign pixel_in_sq = in_square(PW'(hcount_in), PW'(vcount_in));
    assign glove_in_sq = in_square(xpos, ypos);

    //******************************************************************
    // Registers
    //******************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            counter    <= '0;
            is_scored  <= 1'b0;
            round_done <= 1'b0;
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            state      <= state_nxt;
            counter    <= counter_nxt;
            is_scored  <= is_scored_nxt;
            round_done <= round_done_nxt;
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb_out    <= rgb_nxt;
        end
    end

    //******************************************************************
    // Keeper FSM
    //******************************************************************
    always_comb begin
        state_nxt      = state;
        counter_nxt    = counter + 1'b1;
        rgb_nxt        = rgb_in;
        is_scored_nxt  = 1'b0;
        round_done_nxt = 1'b0;
        case (state)
            IDLE: begin
                counter_nxt = '0;
                if (game_state == game_pkg::KEEPER) begin
                    state_nxt = ENGAGE;
                end
            end
            ENGAGE: begin
                if (game_state != game_pkg::KEEPER) begin
                    state_nxt   = IDLE; // Round called off.
                    counter_nxt = '0;
                end else if (counter == SEC_END) begin
                    state_nxt   = COUNTDOWN;
                    counter_nxt = '0;
                end
            end
            COUNTDOWN: begin
                if (pixel_in_sq) begin
                    rgb_nxt = game_pkg::COLOR_AIM;
                end
                if (counter == SEC_END) begin
                    state_nxt   = RESULT;
                    counter_nxt = '0;
                end
            end
            RESULT: begin
                counter_nxt = '0;
                state_nxt   = glove_in_sq ? SAVE : GOAL;
            end
            GOAL, SAVE: begin
                is_scored_nxt = (state == GOAL);
                if (pixel_in_sq) begin
                    rgb_nxt = (state == GOAL) ? game_pkg::COLOR_GOAL : game_pkg::COLOR_SAVE;
                end
                if (counter == RES_END) begin
                    state_nxt      = TERMINATE;
                    counter_nxt    = '0;
                    round_done_nxt = 1'b1;
                end
            end
            default: begin
                state_nxt   = IDLE; // Terminate or an illegal code.
                counter_nxt = '0;
            end
        endcase
    end

    a_done_single: assert property (
        @(posedge clk) disable iff (rst) round_done |=> !round_done
    );

endmodule

// File: source/round_control.sv
// Round sequencer and score counter
`timescale 1ns/1ns

module round_control (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       shot_valid,
    output logic                       shot_ready,
    input  logic [game_pkg::POS_W-1:0] shot_xpos,
    input  logic [game_pkg::POS_W-1:0] shot_ypos,
    output logic [game_pkg::POS_W-1:0] shot_xpos_q,
    output logic [game_pkg::POS_W-1:0] shot_ypos_q,
    output game_pkg::g_state           game_state,
    input  logic                       round_done,
    input  logic                       is_scored,
    output logic [7:0]                 goals,
    output logic [7:0]                 saves
);

    logic shot_xfer;

    assign shot_ready = (game_state == game_pkg::IDLE_GAME);
    assign shot_xfer  = shot_valid && shot_ready;

    //******************************************************************
    // Phase and score
    //******************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= game_pkg::IDLE_GAME;
            goals      <= '0;
            saves      <= '0;
        end else begin
            case (game_state)
                game_pkg::IDLE_GAME: begin
                    if (shot_xfer) begin
                        game_state <= game_pkg::KEEPER;
                    end
                end
                game_pkg::KEEPER: begin
                    if (round_done) begin
                        game_state <= game_pkg::SCORE_SHOW;
                        if (is_scored) begin
                            goals <= goals + 1'b1;
                        end else begin
                            saves <= saves + 1'b1;
                        end
                    end
                end
                default: begin
                    game_state <= game_pkg::IDLE_GAME; // One cycle of score show.
                end
            endcase
        end
    end

    // Shot position stays put for the whole round.
    always_ff @(posedge clk) begin
        if (shot_xfer) begin
            shot_xpos_q <= shot_xpos;
            shot_ypos_q <= shot_ypos;
        end
    end

    a_done_in_keeper: assert property (
        @(posedge clk) disable iff (rst) round_done |-> game_state == game_pkg::KEEPER
    );

endmodule

// File: source/background_draw.sv
// Sky and pitch painter
`timescale 1ns/1ns

module background_draw #(
    parameter int HORIZON = 300
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::CNT_W-1:0] hcount_in,
    input  logic [game_pkg::CNT_W-1:0] vcount_in,
    input  logic                       hsync_in,
    input  logic                       vsync_in,
    input  logic                       hblnk_in,
    input  logic                       vblnk_in,
    output logic [game_pkg::CNT_W-1:0] hcount_out,
    output logic [game_pkg::CNT_W-1:0] vcount_out,
    output logic                       hsync_out,
    output logic                       vsync_out,
    output logic                       hblnk_out,
    output logic                       vblnk_out,
    output logic [game_pkg::RGB_W-1:0] rgb_out
);

    localparam int CW = game_pkg::CNT_W;

    delay #(
        .CLK_DEL(1),
        .WIDTH  (2 * CW + 4)
    ) u_delay_timing (
        .clk (clk),
        .rst (rst),
        .din ({hcount_in, vcount_in, hsync_in, vsync_in, hblnk_in, vblnk_in}),
        .dout({hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out})
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out <= '0;
        end else if (hblnk_in || vblnk_in) begin
            rgb_out <= game_pkg::COLOR_BLANK;
        end else if (vcount_in < CW'(HORIZON)) begin
            rgb_out <= game_pkg::COLOR_SKY;
        end else begin
            rgb_out <= game_pkg::COLOR_GRASS; // Pitch below the horizon.
        end
    end

endmodule

// File: source/vga_timing.sv
// VGA timing generator
`timescale 1ns/1ns

module vga_timing #(
    parameter int H_ACTIVE     = 1024,
    parameter int H_TOTAL      = 1344,
    parameter int H_SYNC_START = 1048,
    parameter int H_SYNC_END   = 1184,
    parameter int V_ACTIVE     = 768,
    parameter int V_TOTAL      = 806,
    parameter int V_SYNC_START = 771,
    parameter int V_SYNC_END   = 777
) (
    input  logic                      clk,
    input  logic                      rst,
    output logic [game_pkg::CNT_W-1:0] hcount,
    output logic [game_pkg::CNT_W-1:0] vcount,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      hblnk,
    output logic                      vblnk
);

    localparam int CW = game_pkg::CNT_W;

    logic h_last;
    logic v_last;

    assign h_last = (hcount == CW'(H_TOTAL - 1));
    assign v_last = (vcount == CW'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (h_last) begin
            hcount <= '0;
            vcount <= v_last ? '0 : vcount + 1'b1; // Next line.
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Sync and blanking follow the counters in the same cycle.
    assign hsync = (hcount >= CW'(H_SYNC_START)) && (hcount < CW'(H_SYNC_END));
    assign vsync = (vcount >= CW'(V_SYNC_START)) && (vcount < CW'(V_SYNC_END));
    assign hblnk = (hcount >= CW'(H_ACTIVE));
    assign vblnk = (vcount >= CW'(V_ACTIVE));

    a_hcount_range: assert property (
        @(posedge clk) disable iff (rst) hcount < CW'(H_TOTAL)
    );

endmodule

// File: source/delay.sv
// Shift register delay line
`timescale 1ns/1ns

module delay #(
    parameter int CLK_DEL = 1,
    parameter int WIDTH   = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stage [CLK_DEL];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CLK_DEL; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < CLK_DEL; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[CLK_DEL-1]; // Oldest stage.

endmodule

// File: source/game_pkg.sv
// Penalty game shared definitions
package game_pkg;

    //******************************************************************
    // Widths
    //******************************************************************
    localparam int POS_W = 12; // Pixel coordinates.
    localparam int CNT_W = 11; // VGA counters.
    localparam int RGB_W = 12; // 4-4-4 colour word.

    // Round phase, driven by round control.
    typedef enum logic [1:0] {
        IDLE_GAME,
        KEEPER,
        SCORE_SHOW
    } g_state;

    //******************************************************************
    // Colours
    //******************************************************************
    localparam logic [RGB_W-1:0] COLOR_SKY   = 12'h8CF;
    localparam logic [RGB_W-1:0] COLOR_GRASS = 12'h070;
    localparam logic [RGB_W-1:0] COLOR_AIM   = 12'h00F; // Blue.
    localparam logic [RGB_W-1:0] COLOR_GOAL  = 12'hF00; // Red.
    localparam logic [RGB_W-1:0] COLOR_SAVE  = 12'h0F0; // Green.
    localparam logic [RGB_W-1:0] COLOR_BLANK = 12'h000;

endpackage
